// File: verilog/trap_params.svh
////////////////////////////////////////////////////////////////////////////
// Global sizes of the trap pipeline: data width, interrupt line count,
// cause code width and the machine CSR addresses of the write port
////////////////////////////////////////////////////////////////////////////

`ifndef TRAP_PARAMS_SVH
`define TRAP_PARAMS_SVH

// Width of program counters, CSR words and CSR write data
`define TRAP_XLEN 32

// Number of interrupt request lines, also the width of mie
`define TRAP_NUM_IRQ 16

// Width of the exception or interrupt code kept in mcause
`define TRAP_CODE_W 5

// Machine mode CSR addresses decoded by the CSR write port
`define TRAP_CSR_MSTATUS 12'h300
`define TRAP_CSR_MIE 12'h304

`endif

// File: verilog/trap_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types of the trap pipeline: exception cause codes, the mcause
// word with its two views, the stage record and the irq selection result
////////////////////////////////////////////////////////////////////////////

`include "trap_params.svh"

package trap_pkg;

  // Synchronous exception codes as they land in mcause
  // Code 12 is reused locally for an instruction bus error
  typedef enum logic [`TRAP_CODE_W-1:0] {
    CAUSE_INSTR_FAULT     = 5'd1,
    CAUSE_ILLEGAL         = 5'd2,
    CAUSE_BREAKPOINT      = 5'd3,
    CAUSE_ECALL_M         = 5'd11,
    CAUSE_INSTR_BUS_FAULT = 5'd12
  } cause_e;

  // Decoded view of mcause, interrupt flag in the MSB and code at the bottom
  typedef struct packed {
    logic                                  irq;
    logic [`TRAP_XLEN-`TRAP_CODE_W-2:0]    rsvd;
    logic [`TRAP_CODE_W-1:0]               code;
  } mcause_fld_t;

  // The same 32 bits seen as the raw CSR word or as flag plus code
  typedef union packed {
    logic [`TRAP_XLEN-1:0] raw;
    mcause_fld_t           fld;
  } mcause_u;

  // Decision made in stage 1 and carried to the CSR stage
  typedef struct packed {
    logic [`TRAP_XLEN-1:0]   pc;
    logic                    is_trap;
    logic                    is_irq;
    logic [`TRAP_CODE_W-1:0] code;
    logic                    is_mret;
  } trap_rec_t;

  // Result of the interrupt priority search
  // When hit is low the index carries no meaning
  typedef struct packed {
    logic                    hit;
    logic [`TRAP_CODE_W-1:0] idx;
  } irq_sel_t;

endpackage

// File: verilog/retire_if.sv
////////////////////////////////////////////////////////////////////////////
// Valid/ready link that carries decided records from the detect stage
// to the CSR stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface retire_if;

  // A record moves on a rising edge where valid and ready are both high
  // Once valid is raised it stays up and rec holds until that edge
  logic                valid;
  logic                ready;
  trap_pkg::trap_rec_t rec;

  // Producer side, owned by the detect stage
  modport src (
    output valid,
    output rec,
    input  ready
  );

  // Consumer side, owned by the CSR stage
  modport dst (
    input  valid,
    input  rec,
    output ready
  );

endinterface

// File: verilog/trap_detect.sv
////////////////////////////////////////////////////////////////////////////
// Stage 1 of the trap pipeline: accepts retiring instructions, samples the
// interrupt lines and resolves the trap priority into a one-entry register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "trap_params.svh"

module trap_detect (
  input  logic                     clk,
  input  logic                     rst_ni,

  // Retire stream with already decoded exception flags
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  logic [`TRAP_XLEN-1:0]    in_pc_i,
  input  logic                     in_mpu_err_i,
  input  logic                     in_bus_err_i,
  input  logic                     in_illegal_i,
  input  logic                     in_ecall_i,
  input  logic                     in_ebreak_i,
  input  logic                     in_mret_i,

  // Interrupt lines and their enables from the CSR stage
  input  logic [`TRAP_NUM_IRQ-1:0] irq_i,
  input  logic [`TRAP_NUM_IRQ-1:0] mie_i,
  input  logic                     irq_enable_i,
  output logic                     irq_ack_o,

  retire_if.src                    out_if
);

  logic                     started_q;
  logic                     valid_q;
  trap_pkg::trap_rec_t      rec_q;
  trap_pkg::trap_rec_t      rec_d;
  trap_pkg::irq_sel_t       irq_sel;
  logic [`TRAP_NUM_IRQ-1:0] irq_pend;
  logic                     irq_gate;
  logic                     accept;

  ////////////////////////////////////////////////////////////////////////////
  // Interrupt selection
  ////////////////////////////////////////////////////////////////////////////

  // A trap already waiting here will clear MIE on commit, so no second
  // interrupt may be taken behind it
  assign irq_gate = irq_enable_i & ~(valid_q & rec_q.is_trap);
  assign irq_pend = irq_i & mie_i & {`TRAP_NUM_IRQ{irq_gate}};

  // Walk from the top so the lowest pending line is written last and wins
  always_comb begin
    irq_sel = '0;
    for (int i = `TRAP_NUM_IRQ - 1; i >= 0; i--) begin
      if (irq_pend[i]) begin
        irq_sel.hit = 1'b1;
        irq_sel.idx = i[`TRAP_CODE_W-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Priority resolution
  ////////////////////////////////////////////////////////////////////////////

  // An interrupt replaces the instruction, then exceptions in fixed order
  // MRET only counts when nothing else fires
  always_comb begin
    rec_d         = '0;
    rec_d.pc      = in_pc_i;
    rec_d.is_trap = 1'b1;
    if (irq_sel.hit) begin
      rec_d.is_irq = 1'b1;
      rec_d.code   = irq_sel.idx;
    end else if (in_mpu_err_i) begin
      rec_d.code = trap_pkg::CAUSE_INSTR_FAULT;
    end else if (in_bus_err_i) begin
      rec_d.code = trap_pkg::CAUSE_INSTR_BUS_FAULT;
    end else if (in_illegal_i) begin
      rec_d.code = trap_pkg::CAUSE_ILLEGAL;
    end else if (in_ecall_i) begin
      rec_d.code = trap_pkg::CAUSE_ECALL_M;
    end else if (in_ebreak_i) begin
      rec_d.code = trap_pkg::CAUSE_BREAKPOINT;
    end else begin
      rec_d.is_trap = 1'b0;
      rec_d.is_mret = in_mret_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage register and handshakes
  ////////////////////////////////////////////////////////////////////////////

  // Ready only after the first edge out of reset, then whenever the entry
  // is free or leaves in this cycle
  assign in_ready_o = started_q & (~valid_q | out_if.ready);
  assign accept     = in_valid_i & in_ready_o;

  // The acknowledge marks the instruction that was turned into an interrupt
  assign irq_ack_o = accept & irq_sel.hit;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      started_q <= 1'b1;
      if (accept) begin
        valid_q <= 1'b1;
      end else if (out_if.ready) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rec_q <= rec_d;
    end
  end

  assign out_if.valid = valid_q;
  assign out_if.rec   = rec_q;

endmodule

// File: verilog/trap_csr.sv
////////////////////////////////////////////////////////////////////////////
// Stage 2 of the trap pipeline: machine trap CSRs, record commit, the CSR
// write port and the one-entry trap report register with valid/ready
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "trap_params.svh"

module trap_csr (
  input  logic                     clk,
  input  logic                     rst_ni,

  // Decided records from the detect stage
  retire_if.dst                    in_if,

  // CSR write port for mstatus and mie
  input  logic                     csr_we_i,
  input  logic [11:0]              csr_addr_i,
  input  logic [`TRAP_XLEN-1:0]    csr_wdata_i,

  // Trap report handshake
  output logic                     trap_valid_o,
  input  logic                     trap_ready_i,
  output logic [`TRAP_XLEN-1:0]    trap_pc_o,
  output trap_pkg::mcause_u        trap_mcause_o,

  // Interrupt permission back to stage 1
  output logic                     irq_enable_o,

  // Architectural CSR state
  output logic [`TRAP_XLEN-1:0]    mepc_o,
  output trap_pkg::mcause_u        mcause_o,
  output logic                     mstatus_mie_o,
  output logic                     mstatus_mpie_o,
  output logic [`TRAP_NUM_IRQ-1:0] mie_o
);

  // Bit positions of MIE and MPIE inside the mstatus word
  localparam int unsigned mstatus_mie_pos  = 3;
  localparam int unsigned mstatus_mpie_pos = 7;

  logic [`TRAP_XLEN-1:0]    mepc_q;
  trap_pkg::mcause_u        mcause_q;
  trap_pkg::mcause_u        mcause_d;
  logic                     mstatus_mie_q;
  logic                     mstatus_mpie_q;
  logic [`TRAP_NUM_IRQ-1:0] mie_q;

  logic                     out_valid_q;
  logic [`TRAP_XLEN-1:0]    out_pc_q;
  trap_pkg::mcause_u        out_cause_q;

  logic                     commit;
  logic                     commit_trap;
  logic                     commit_mret;
  logic                     csr_wr;

  ////////////////////////////////////////////////////////////////////////////
  // Commit control
  ////////////////////////////////////////////////////////////////////////////

  // A stalled report freezes the whole stage, so CSRs never run ahead of it
  assign in_if.ready = ~out_valid_q | trap_ready_i;
  assign commit      = in_if.valid & in_if.ready;
  assign commit_trap = commit & in_if.rec.is_trap;
  assign commit_mret = commit & in_if.rec.is_mret;

  // Software writes lose against any record commit in the same cycle
  assign csr_wr = csr_we_i & ~commit;

  // New mcause is assembled through its decoded view
  always_comb begin
    mcause_d          = '0;
    mcause_d.fld.irq  = in_if.rec.is_irq;
    mcause_d.fld.code = in_if.rec.code;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Machine trap CSRs
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mepc_q         <= '0;
      mcause_q       <= '0;
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mie_q          <= '0;
    end else if (commit_trap) begin
      // Trap entry saves the pc and cause and stacks the interrupt enable
      mepc_q         <= in_if.rec.pc;
      mcause_q       <= mcause_d;
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;
    end else if (commit_mret) begin
      // Return pops the stacked enable and leaves MPIE set
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
    end else if (csr_wr) begin
      if (csr_addr_i == `TRAP_CSR_MSTATUS) begin
        mstatus_mie_q  <= csr_wdata_i[mstatus_mie_pos];
        mstatus_mpie_q <= csr_wdata_i[mstatus_mpie_pos];
      end
      if (csr_addr_i == `TRAP_CSR_MIE) begin
        mie_q <= csr_wdata_i[`TRAP_NUM_IRQ-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Trap report register
  ////////////////////////////////////////////////////////////////////////////

  // A trap can load while the previous report drains in the same cycle
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (commit_trap) begin
      out_valid_q <= 1'b1;
    end else if (trap_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (commit_trap) begin
      out_pc_q    <= in_if.rec.pc;
      out_cause_q <= mcause_d;
    end
  end

  // No interrupt while MIE is off or a taken trap is still being reported
  assign irq_enable_o = mstatus_mie_q & ~out_valid_q;

  assign trap_valid_o   = out_valid_q;
  assign trap_pc_o      = out_pc_q;
  assign trap_mcause_o  = out_cause_q;
  assign mepc_o         = mepc_q;
  assign mcause_o       = mcause_q;
  assign mstatus_mie_o  = mstatus_mie_q;
  assign mstatus_mpie_o = mstatus_mpie_q;
  assign mie_o          = mie_q;

endmodule

// File: verilog/trap_top.sv
////////////////////////////////////////////////////////////////////////////
// Top level of the trap pipeline: detect stage, CSR stage and the
// record link between them, brought out on plain ports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "trap_params.svh"

module trap_top (
  input  logic                     clk,
  input  logic                     rst_ni,

  // Retire stream
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  logic [`TRAP_XLEN-1:0]    in_pc_i,
  input  logic                     in_mpu_err_i,
  input  logic                     in_bus_err_i,
  input  logic                     in_illegal_i,
  input  logic                     in_ecall_i,
  input  logic                     in_ebreak_i,
  input  logic                     in_mret_i,

  // Interrupt lines
  input  logic [`TRAP_NUM_IRQ-1:0] irq_i,

  // CSR write port
  input  logic                     csr_we_i,
  input  logic [11:0]              csr_addr_i,
  input  logic [`TRAP_XLEN-1:0]    csr_wdata_i,

  // Trap report
  output logic                     trap_valid_o,
  input  logic                     trap_ready_i,
  output logic [`TRAP_XLEN-1:0]    trap_pc_o,
  output logic [`TRAP_XLEN-1:0]    trap_mcause_o,
  output logic                     irq_ack_o,

  // CSR state
  output logic [`TRAP_XLEN-1:0]    mepc_o,
  output logic [`TRAP_XLEN-1:0]    mcause_o,
  output logic                     mstatus_mie_o,
  output logic                     mstatus_mpie_o,
  output logic [`TRAP_NUM_IRQ-1:0] mie_o
);

  logic              irq_enable;
  trap_pkg::mcause_u csr_mcause;
  trap_pkg::mcause_u trap_cause;

  retire_if stage_if ();

  trap_detect u_detect (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_pc_i      (in_pc_i),
    .in_mpu_err_i (in_mpu_err_i),
    .in_bus_err_i (in_bus_err_i),
    .in_illegal_i (in_illegal_i),
    .in_ecall_i   (in_ecall_i),
    .in_ebreak_i  (in_ebreak_i),
    .in_mret_i    (in_mret_i),
    .irq_i        (irq_i),
    .mie_i        (mie_o),
    .irq_enable_i (irq_enable),
    .irq_ack_o    (irq_ack_o),
    .out_if       (stage_if.src)
  );

  trap_csr u_csr (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .in_if          (stage_if.dst),
    .csr_we_i       (csr_we_i),
    .csr_addr_i     (csr_addr_i),
    .csr_wdata_i    (csr_wdata_i),
    .trap_valid_o   (trap_valid_o),
    .trap_ready_i   (trap_ready_i),
    .trap_pc_o      (trap_pc_o),
    .trap_mcause_o  (trap_cause),
    .irq_enable_o   (irq_enable),
    .mepc_o         (mepc_o),
    .mcause_o       (csr_mcause),
    .mstatus_mie_o  (mstatus_mie_o),
    .mstatus_mpie_o (mstatus_mpie_o),
    .mie_o          (mie_o)
  );

  // Outside the core mcause is only seen as the raw CSR word
  assign mcause_o      = csr_mcause.raw;
  assign trap_mcause_o = trap_cause.raw;

endmodule

// File: tests/trap_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench of the trap pipeline with clock and reset, random and directed
// retire stimulus, a queue of expected traps and assertion based checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "trap_params.svh"

module trap_tb;

  logic                     clk;
  logic                     rst_ni;
  logic                     in_valid_i;
  logic                     in_ready_o;
  logic [`TRAP_XLEN-1:0]    in_pc_i;
  logic                     in_mpu_err_i;
  logic                     in_bus_err_i;
  logic                     in_illegal_i;
  logic                     in_ecall_i;
  logic                     in_ebreak_i;
  logic                     in_mret_i;
  logic [`TRAP_NUM_IRQ-1:0] irq_i;
  logic                     csr_we_i;
  logic [11:0]              csr_addr_i;
  logic [`TRAP_XLEN-1:0]    csr_wdata_i;
  logic                     trap_valid_o;
  logic                     trap_ready_i;
  logic                     irq_ack_o;
  logic [`TRAP_XLEN-1:0]    trap_pc_o;
  logic [`TRAP_XLEN-1:0]    trap_mcause_o;
  logic [`TRAP_XLEN-1:0]    mepc_o;
  logic [`TRAP_XLEN-1:0]    mcause_o;
  logic                     mstatus_mie_o;
  logic                     mstatus_mpie_o;
  logic [`TRAP_NUM_IRQ-1:0] mie_o;

  // Reference state that follows the commit rules in program order
  logic                     model_mie;
  logic                     model_mpie;
  logic [`TRAP_NUM_IRQ-1:0] mie_val;
  logic                     rand_ready;
  logic [`TRAP_XLEN-1:0]    exp_pc_q[$];
  logic [`TRAP_XLEN-1:0]    exp_cause_q[$];

  trap_top trap_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    abort_run();
  endtask

  task automatic fail_with(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp,
                          input logic [31:0] act);
    assert (act === exp) else show_mismatch(name, exp, act);
  endtask

  // Compares the status bits and mie with the reference while the pipe is idle
  task automatic check_csrs();
    check_eq("mstatus_mie_o", 32'(model_mie), 32'(mstatus_mie_o));
    check_eq("mstatus_mpie_o", 32'(model_mpie), 32'(mstatus_mpie_o));
    check_eq("mie_o", 32'(mie_val), 32'(mie_o));
  endtask

  // Exception code by priority of MPU fault, bus error, illegal, ECALL and EBREAK
  // Bit 5 of the flag vector is the MPU fault and bit 0 is MRET
  function automatic logic [`TRAP_CODE_W-1:0] exc_code(input logic [5:0] f);
    if (f[5]) return 5'd1;
    if (f[4]) return 5'd12;
    if (f[3]) return 5'd2;
    if (f[2]) return 5'd11;
    return 5'd3;
  endfunction

  // Returns the lowest numbered line set in the vector and -1 when none is set
  function automatic int lowest_line(input logic [`TRAP_NUM_IRQ-1:0] pend);
    for (int i = 0; i < `TRAP_NUM_IRQ; i++) begin
      if (pend[i]) return i;
    end
    return -1;
  endfunction

  // Every report transfer must match the oldest expected trap
  // CSRs commit with the report, so mepc and mcause must agree with it
  always @(negedge clk) begin
    if (rst_ni && trap_valid_o && trap_ready_i) begin
      if (exp_pc_q.size() == 0) begin
        fail_with("trap reported while none was expected");
      end else begin
        check_eq("trap_pc_o", exp_pc_q[0], trap_pc_o);
        check_eq("trap_mcause_o", exp_cause_q[0], trap_mcause_o);
        check_eq("mepc_o", exp_pc_q[0], mepc_o);
        check_eq("mcause_o", exp_cause_q[0], mcause_o);
        void'(exp_pc_q.pop_front());
        void'(exp_cause_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks that start and end 1 ns after a rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_instr(input logic [31:0] pc, input logic [5:0] f);
    int waited;
    int irq_line;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    // Interrupt prediction holds only while nothing else is in flight
    irq_line = model_mie ? lowest_line(irq_i & mie_val) : -1;
    in_valid_i = 1'b1;
    in_pc_i    = pc;
    {in_mpu_err_i, in_bus_err_i, in_illegal_i, in_ecall_i, in_ebreak_i, in_mret_i} = f;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_ready_o;
      if (!accepted) begin
        waited++;
        if (waited > 40) fail_with("retire handshake did not complete");
        @(posedge clk);
        #1;
        if (rand_ready) trap_ready_i = ($urandom % 2) == 0;
      end
    end
    check_eq("irq_ack_o", 32'(irq_line >= 0), 32'(irq_ack_o));
    if (irq_line >= 0 || f[5:1] != 5'b0) begin
      exp_pc_q.push_back(pc);
      if (irq_line >= 0) exp_cause_q.push_back({1'b1, 26'b0, 5'(irq_line)});
      else exp_cause_q.push_back({27'b0, exc_code(f)});
      model_mpie = model_mie;
      model_mie  = 1'b0;
    end else if (f[0]) begin
      model_mie  = model_mpie;
      model_mpie = 1'b1;
    end
    @(posedge clk);
    #1;
    in_valid_i = 1'b0;
  endtask

  // Only issued with the pipe idle, so no commit can override the write
  task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
    csr_we_i    = 1'b1;
    csr_addr_i  = addr;
    csr_wdata_i = data;
    @(posedge clk);
    #1;
    csr_we_i = 1'b0;
    if (addr == `TRAP_CSR_MSTATUS) begin
      model_mie  = data[3];
      model_mpie = data[7];
    end else begin
      mie_val = data[`TRAP_NUM_IRQ-1:0];
    end
  endtask

  // Waits for all expected traps to be reported, then lets stage 1 empty
  task automatic wait_idle();
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > 60) fail_with("pipeline did not drain");
    end while (exp_pc_q.size() != 0 || trap_valid_o);
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int waited;
    logic [31:0] pc_a;
    void'($urandom(32'h45e0));
    rst_ni = 1'b0;
    in_valid_i = 1'b0;
    in_pc_i = '0;
    {in_mpu_err_i, in_bus_err_i, in_illegal_i, in_ecall_i, in_ebreak_i, in_mret_i} = '0;
    irq_i = '0;
    csr_we_i = 1'b0;
    csr_addr_i = '0;
    csr_wdata_i = '0;
    trap_ready_i = 1'b1;
    model_mie = 1'b0;
    model_mpie = 1'b0;
    mie_val = '0;
    rand_ready = 1'b0;
    repeat (3) @(posedge clk);
    #1 rst_ni = 1'b1;

    // Reset state is checked before the first edge out of reset
    @(negedge clk);
    check_eq("in_ready_o", 32'h0, 32'(in_ready_o));
    check_eq("trap_valid_o", 32'h0, 32'(trap_valid_o));
    check_eq("irq_ack_o", 32'h0, 32'(irq_ack_o));
    check_eq("mepc_o", 32'h0, mepc_o);
    check_eq("mcause_o", 32'h0, mcause_o);
    check_csrs();
    @(posedge clk);
    #1;

    // Random flag mixes with a randomly stalling trap output
    rand_ready = 1'b1;
    for (int n = 0; n < 60; n++) begin
      trap_ready_i = ($urandom % 4) != 0;
      send_instr(32'($urandom) & 32'hffff_fffc, 6'($urandom) & 6'($urandom));
    end
    rand_ready = 1'b0;
    trap_ready_i = 1'b1;
    wait_idle();
    check_csrs();

    // Interrupt gating with line 2 pending but never enabled
    irq_i = 16'h00a4;
    write_csr(`TRAP_CSR_MSTATUS, 32'h0);
    write_csr(`TRAP_CSR_MIE, 32'h0000_00a0);
    send_instr(32'h0000_0100, 6'b0);
    wait_idle();
    write_csr(`TRAP_CSR_MSTATUS, 32'h0000_0008);
    write_csr(`TRAP_CSR_MIE, 32'h0);
    send_instr(32'h0000_0104, 6'b0);
    wait_idle();
    write_csr(`TRAP_CSR_MIE, 32'h0000_00a0);
    // The interrupt wins over the ECALL on the same instruction
    send_instr(32'h0000_0108, 6'b000100);
    wait_idle();
    check_csrs();
    check_eq("mstatus_mpie_o", 32'h1, 32'(mstatus_mpie_o));

    // Return restores MIE from MPIE and gives no report
    irq_i = '0;
    send_instr(32'h0000_010c, 6'b000001);
    wait_idle();
    check_csrs();

    // The report is visible one edge after the trap leaves stage 1
    send_instr(32'h0000_4000, 6'b000100);
    @(negedge clk);
    check_eq("trap_valid_o", 32'h0, 32'(trap_valid_o));
    @(negedge clk);
    check_eq("trap_valid_o", 32'h1, 32'(trap_valid_o));
    wait_idle();

    // Back-pressure holds the report and then stalls the retire input
    pc_a = 32'h0000_8000;
    trap_ready_i = 1'b0;
    send_instr(pc_a, 6'b001000);
    send_instr(32'h0000_8004, 6'b000010);
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > 10) fail_with("in_ready_o stayed high under back-pressure");
    end while (in_ready_o);
    repeat (4) begin
      @(negedge clk);
      check_eq("trap_valid_o", 32'h1, 32'(trap_valid_o));
      check_eq("trap_pc_o", pc_a, trap_pc_o);
      check_eq("trap_mcause_o", 32'd2, trap_mcause_o);
    end
    @(posedge clk);
    #1 trap_ready_i = 1'b1;
    wait_idle();

    if (exp_pc_q.size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("Error: %0d expected traps were never reported", exp_pc_q.size());
      abort_run();
    end
  end

endmodule

// File: sim.f
+incdir+verilog
verilog/trap_pkg.sv
verilog/retire_if.sv
verilog/trap_detect.sv
verilog/trap_csr.sv
verilog/trap_top.sv
tests/trap_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the trap pipeline testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Mdir obj_dir -f sim.f --top-module trap_tb

./obj_dir/Vtrap_tb | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
